/* build.f */
source/game_pkg.sv
source/tick_timer.sv
source/wind_model.sv
source/throw_ctl.sv
source/hit_detect.sv
source/throw_unit.sv
testbench/throw_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module throw_unit_tb -f build.f
./obj_dir/Vthrow_unit_tb | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

/* source/game_pkg.sv */
package game_pkg;

    // ----------------------------------------------------------------------
    // screen and launch point
    // ----------------------------------------------------------------------
    localparam int VER_PIXELS = 768;
    localparam int START_X    = 140;
    localparam int START_Y    = 350;
    // physics height where a flight is over
    localparam int FLOOR_Y    = 190;
    localparam int COORD_W    = 12;

    // ----------------------------------------------------------------------
    // physics, all per tick
    // ----------------------------------------------------------------------
    localparam int INIT_VELOCITY = 27;
    localparam int GRAVITY       = 1;
    // percent of the throw force that becomes horizontal speed
    localparam int FORCE_SCALE   = 18;
    localparam int WIND_CENTER   = 50;
    localparam int WIND_MAX      = 5;

    // ----------------------------------------------------------------------
    // obstacles, rows counted from the top of the screen
    // ----------------------------------------------------------------------
    localparam int WALL_LEFT   = 490;
    localparam int WALL_RIGHT  = 534;
    localparam int WALL_TOP    = 241;
    // half the projectile size
    localparam int WALL_MARGIN = 15;

    localparam int TARGET_LEFT   = 867;
    localparam int TARGET_RIGHT  = 1024;
    localparam int TARGET_TOP    = 427;
    localparam int TARGET_BOTTOM = 525;

    // about 20 ms at a 65 MHz pixel clock
    localparam int TICK_CYCLES_DEFAULT = 1300000;

    typedef enum logic [1:0] {IDLE, RISE, FALL, DONE} flight_t;

endpackage

/* source/hit_detect.sv */
`timescale 1ns/1ps

module hit_detect (
    input  logic                                clk,
    input  logic                                rst,
    input  logic signed [game_pkg::COORD_W-1:0] x_pos,
    input  logic signed [game_pkg::COORD_W-1:0] y_pos,
    output logic                                hit
);

    import game_pkg::*;

    int   row;
    logic in_box;
    logic in_box_d;

    // physics y grows upward, screen rows grow downward
    always_comb begin
        row    = VER_PIXELS - int'(y_pos);
        in_box = row >= TARGET_TOP && row <= TARGET_BOTTOM &&
                 int'(x_pos) >= TARGET_LEFT && int'(x_pos) <= TARGET_RIGHT;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_box_d <= 1'b0;
            hit      <= 1'b0;
        end else begin
            in_box_d <= in_box;
            // entry edge only
            hit      <= in_box && !in_box_d;
        end
    end

endmodule

/* source/throw_ctl.sv */
`timescale 1ns/1ps

module throw_ctl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                enable,
    input  logic                                tick,
    input  logic signed [game_pkg::COORD_W-1:0] drift,
    output logic signed [game_pkg::COORD_W-1:0] x_pos,
    output logic signed [game_pkg::COORD_W-1:0] y_pos,
    output logic                                throw_done
);

    import game_pkg::*;

    flight_t state;

    // ticks since launch or since the apex
    logic        [COORD_W-1:0] t_cnt;
    logic signed [COORD_W-1:0] x_org;
    logic signed [COORD_W-1:0] y_org;

    int t_next;
    int x_calc;
    int y_calc;
    int row_now;
    int row_calc;

    logic                      apex;
    logic                      in_wall_now;
    logic                      in_wall_next;
    logic                      hold_x;
    logic                      on_wall_top;
    logic                      at_floor;
    logic signed [COORD_W-1:0] x_step;
    logic signed [COORD_W-1:0] y_step;
    logic signed [COORD_W-1:0] x_fall;

    // ----------------------------------------------------------------------
    // closed-form trajectory for the coming tick
    // ----------------------------------------------------------------------
    always_comb begin
        t_next = int'(t_cnt) + 1;
        x_calc = int'(x_org) + int'(drift) * t_next;
        y_calc = int'(y_org) - (GRAVITY * t_next * t_next) / 2;
        if (state == RISE) begin
            y_calc = y_calc + INIT_VELOCITY * t_next;
        end
        x_step = COORD_W'(x_calc);
        y_step = COORD_W'(y_calc);

        // vertical speed used up
        apex = (INIT_VELOCITY - GRAVITY * t_next) <= 0;

        row_now  = VER_PIXELS - int'(y_pos);
        row_calc = VER_PIXELS - y_calc;

        // against the wall face, below its top
        in_wall_now = int'(x_pos) >= WALL_LEFT - WALL_MARGIN &&
                      int'(x_pos) <= WALL_RIGHT + WALL_MARGIN;
        hold_x = row_now > WALL_TOP && in_wall_now;
        x_fall = hold_x ? x_pos : x_step;

        in_wall_next = int'(x_fall) >= WALL_LEFT - WALL_MARGIN &&
                       int'(x_fall) <= WALL_RIGHT + WALL_MARGIN;
        on_wall_top  = row_calc <= WALL_TOP && row_calc >= WALL_TOP - WALL_MARGIN &&
                       in_wall_next;
        at_floor     = y_calc <= FLOOR_Y;
    end

    // ----------------------------------------------------------------------
    // flight FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            t_cnt      <= '0;
            x_pos      <= COORD_W'(START_X);
            y_pos      <= COORD_W'(START_Y);
            throw_done <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    throw_done <= 1'b0;
                    t_cnt      <= '0;
                    x_pos      <= COORD_W'(START_X);
                    y_pos      <= COORD_W'(START_Y);
                    if (enable) begin
                        state <= RISE;
                    end
                end

                RISE: begin
                    if (tick) begin
                        x_pos <= x_step;
                        y_pos <= y_step;
                        if (apex) begin
                            // restart the clock from the top of the arc
                            state <= FALL;
                            t_cnt <= '0;
                        end else begin
                            t_cnt <= t_cnt + 1'b1;
                        end
                    end
                end

                FALL: begin
                    if (tick) begin
                        x_pos <= x_fall;
                        y_pos <= y_step;
                        if (at_floor || on_wall_top) begin
                            state <= DONE;
                        end else begin
                            t_cnt <= t_cnt + 1'b1;
                        end
                    end
                end

                DONE: begin
                    throw_done <= 1'b1;
                    x_pos      <= COORD_W'(START_X);
                    y_pos      <= COORD_W'(START_Y);
                    // wait for enable to drop before rearming
                    if (!enable) begin
                        state <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // origin of the current phase
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            x_org <= COORD_W'(START_X);
            y_org <= COORD_W'(START_Y);
        end else if (state == RISE && tick && apex) begin
            x_org <= x_step;
            y_org <= y_step;
        end
    end

endmodule

/* source/throw_unit.sv */
`timescale 1ns/1ps

module throw_unit #(
    parameter int TICK_CYCLES = game_pkg::TICK_CYCLES_DEFAULT
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                enable,
    input  logic        [9:0]                   throw_force,
    input  logic        [6:0]                   wind_force,
    output logic signed [game_pkg::COORD_W-1:0] x_pos,
    output logic signed [game_pkg::COORD_W-1:0] y_pos,
    output logic                                hit,
    output logic                                throw_done
);

    import game_pkg::*;

    logic                      tick;
    logic signed [COORD_W-1:0] drift;

    tick_timer #(
        .TICK_CYCLES(TICK_CYCLES)
    ) u_tick_timer (
        .clk (clk),
        .rst (rst),
        .tick(tick)
    );

    wind_model u_wind_model (
        .throw_force(throw_force),
        .wind_force (wind_force),
        .drift      (drift)
    );

    throw_ctl u_throw_ctl (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .tick      (tick),
        .drift     (drift),
        .x_pos     (x_pos),
        .y_pos     (y_pos),
        .throw_done(throw_done)
    );

    // checks the same coordinates that leave the top
    hit_detect u_hit_detect (
        .clk  (clk),
        .rst  (rst),
        .x_pos(x_pos),
        .y_pos(y_pos),
        .hit  (hit)
    );

endmodule

/* source/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer #(
    parameter int TICK_CYCLES = game_pkg::TICK_CYCLES_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    // one spare bit so the count never overflows for small divisors
    logic [$clog2(TICK_CYCLES + 1)-1:0] count;
    logic                               last;

    assign last = (int'(count) == TICK_CYCLES - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (last) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // strobe on the wrap cycle only
    assign tick = last;

endmodule

/* source/wind_model.sv */
`timescale 1ns/1ps

module wind_model (
    input  logic        [9:0]                   throw_force,
    input  logic        [6:0]                   wind_force,
    output logic signed [game_pkg::COORD_W-1:0] drift
);

    import game_pkg::*;

    int scaled_force;
    int wind_term;

    always_comb begin
        scaled_force = (int'(throw_force) * FORCE_SCALE) / 100;
    end

    // three zones around the calm setting
    always_comb begin
        if (int'(wind_force) > WIND_CENTER) begin
            // headwind pushes back
            wind_term = -WIND_MAX - ((int'(wind_force) - WIND_CENTER) * WIND_MAX) / 50;
        end else if (int'(wind_force) < WIND_CENTER) begin
            wind_term = WIND_MAX + ((WIND_CENTER - int'(wind_force)) * WIND_MAX) / 50;
        end else begin
            wind_term = 0;
        end
    end

    assign drift = COORD_W'(scaled_force + wind_term);

endmodule

/* testbench/throw_unit_tb.sv */
`timescale 1ns/1ps

module throw_unit_tb;

    import game_pkg::*;

    localparam int TB_TICK     = 4;
    localparam int NUM_ROWS    = 10;
    localparam int NUM_FIXED   = 7;
    // rise plus the longest fall from the apex, in ticks
    localparam int MAX_TICKS   = 64;
    localparam int CYCLE_LIMIT = NUM_ROWS * ((MAX_TICKS + 1) * TB_TICK + 20) + 100;
    localparam int CAUSE_FLOOR = 0;
    localparam int CAUSE_WALL  = 1;

    logic                      clk;
    logic                      rst;
    logic                      enable;
    logic        [9:0]         throw_force;
    logic        [6:0]         wind_force;
    logic signed [COORD_W-1:0] x_pos;
    logic signed [COORD_W-1:0] y_pos;
    logic                      hit;
    logic                      throw_done;

    // force, wind, end cause, hit count, final x; the last rows are random (cause -1)
    int row_force [NUM_ROWS] = '{28, 80, 28, 39, 45, 80, 0, 0, 0, 0};
    int row_wind  [NUM_ROWS] = '{50, 100, 0, 50, 50, 50, 127, 50, 50, 50};
    int row_cause [NUM_ROWS] = '{0, 0, 0, 0, 1, 0, 0, -1, -1, -1};
    int row_hits  [NUM_ROWS] = '{0, 0, 1, 0, 0, 1, 0, 0, 0, 0};
    int row_end_x [NUM_ROWS] = '{440, 380, 1040, 476, 508, 980, -580, 0, 0, 0};

    // reference model state
    flight_t rs;
    int      ex;
    int      ey;
    int      xo;
    int      yo;
    int      t_ref;
    int      drift_ref;
    logic    exp_done;
    logic    exp_hit;
    logic    prev_box;

    int errors;
    int checks;
    int hits_seen;
    int cycles;

    throw_unit #(
        .TICK_CYCLES(TB_TICK)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .throw_force(throw_force),
        .wind_force (wind_force),
        .x_pos      (x_pos),
        .y_pos      (y_pos),
        .hit        (hit),
        .throw_done (throw_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

    // ----------------------------------------------------------------------
    // reference rules
    // ----------------------------------------------------------------------
    function automatic int calc_drift(input int force_v, input int wind_v);
        int wind_term;
        wind_term = 0;
        if (wind_v > WIND_CENTER) begin
            wind_term = -WIND_MAX - ((wind_v - WIND_CENTER) * WIND_MAX) / 50;
        end else if (wind_v < WIND_CENTER) begin
            wind_term = WIND_MAX + ((WIND_CENTER - wind_v) * WIND_MAX) / 50;
        end
        return (force_v * FORCE_SCALE) / 100 + wind_term;
    endfunction

    function automatic logic in_wall(input int x);
        return x >= WALL_LEFT - WALL_MARGIN && x <= WALL_RIGHT + WALL_MARGIN;
    endfunction

    function automatic logic in_target(input int x, input int y);
        int row;
        row = VER_PIXELS - y;
        return row >= TARGET_TOP && row <= TARGET_BOTTOM &&
               x >= TARGET_LEFT && x <= TARGET_RIGHT;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // one clock of the reference, then compare all outputs
    task automatic clock_step();
        logic tick_s;
        logic en_s;
        logic box_now;
        int   t_n;
        int   nx;
        int   ny;
        int   row_new;
        tick_s  = UUT.tick;
        en_s    = enable;
        box_now = in_target(ex, ey);
        @(negedge clk);
        exp_hit  = box_now && !prev_box;
        prev_box = box_now;
        case (rs)
            IDLE: begin
                ex       = START_X;
                ey       = START_Y;
                exp_done = 1'b0;
                if (en_s) begin
                    rs    = RISE;
                    t_ref = 0;
                    xo    = START_X;
                    yo    = START_Y;
                end
            end
            RISE: begin
                if (tick_s) begin
                    t_n = t_ref + 1;
                    ex  = xo + drift_ref * t_n;
                    ey  = yo + INIT_VELOCITY * t_n - (GRAVITY * t_n * t_n) / 2;
                    t_ref = t_n;
                    if (INIT_VELOCITY - GRAVITY * t_n <= 0) begin
                        // apex becomes the new origin
                        rs    = FALL;
                        xo    = ex;
                        yo    = ey;
                        t_ref = 0;
                    end
                end
            end
            FALL: begin
                if (tick_s) begin
                    t_n = t_ref + 1;
                    nx  = xo + drift_ref * t_n;
                    if (VER_PIXELS - ey > WALL_TOP && in_wall(ex)) begin
                        nx = ex;
                    end
                    ny      = yo - (GRAVITY * t_n * t_n) / 2;
                    row_new = VER_PIXELS - ny;
                    ex      = nx;
                    ey      = ny;
                    t_ref   = t_n;
                    if (ny <= FLOOR_Y || (row_new <= WALL_TOP &&
                        row_new >= WALL_TOP - WALL_MARGIN && in_wall(nx))) begin
                        rs = DONE;
                    end
                end
            end
            DONE: begin
                ex       = START_X;
                ey       = START_Y;
                exp_done = 1'b1;
                if (!en_s) begin
                    rs = IDLE;
                end
            end
        endcase
        check_value("x_pos", int'(x_pos), ex);
        check_value("y_pos", int'(y_pos), ey);
        check_value("throw_done", int'(throw_done), int'(exp_done));
        check_value("hit", int'(hit), int'(exp_hit));
        if (hit) begin
            hits_seen++;
        end
    endtask

    // ----------------------------------------------------------------------
    // one throw from idle back to idle
    // ----------------------------------------------------------------------
    task automatic run_row(input int idx);
        int errs_before;
        int last_x;
        int last_y;
        int cause;
        errs_before = errors;
        hits_seen   = 0;
        last_x      = START_X;
        last_y      = START_Y;
        throw_force = 10'(row_force[idx]);
        wind_force  = 7'(row_wind[idx]);
        drift_ref   = calc_drift(row_force[idx], row_wind[idx]);
        enable      = 1'b1;
        clock_step();
        while (!throw_done) begin
            last_x = int'(x_pos);
            last_y = int'(y_pos);
            clock_step();
        end
        // done holds and no new flight starts while enable stays high
        repeat (6) clock_step();
        enable = 1'b0;
        repeat (3) clock_step();
        if (row_cause[idx] >= 0) begin
            cause = (last_y <= FLOOR_Y) ? CAUSE_FLOOR : CAUSE_WALL;
            check_value("end cause", cause, row_cause[idx]);
            check_value("hit count", hits_seen, row_hits[idx]);
            check_value("final x_pos", last_x, row_end_x[idx]);
        end
        $display("row %0d force %0d wind %0d drift %0d: end x %0d, hits %0d, %s",
                 idx, row_force[idx], row_wind[idx], drift_ref, last_x, hits_seen,
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst         = 1'b1;
        enable      = 1'b0;
        throw_force = '0;
        wind_force  = 7'(WIND_CENTER);
        errors      = 0;
        checks      = 0;
        hits_seen   = 0;
        rs          = IDLE;
        ex          = START_X;
        ey          = START_Y;
        xo          = START_X;
        yo          = START_Y;
        t_ref       = 0;
        drift_ref   = 0;
        exp_done    = 1'b0;
        exp_hit     = 1'b0;
        prev_box    = 1'b0;

        void'($urandom(27));
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            row_force[i] = int'($urandom % 100);
            row_wind[i]  = int'($urandom % 101);
        end

        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_value("x_pos", int'(x_pos), START_X);
        check_value("y_pos", int'(y_pos), START_Y);
        check_value("throw_done", int'(throw_done), 0);
        check_value("hit", int'(hit), 0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
